//--- Bender.yml
package:
  name: branch_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/wisc_pkg.sv
      - logic/decode_stage.sv
      - logic/decode_forward.sv
      - logic/branch_resolve.sv
      - logic/execute_stage.sv
      - logic/writeback_stage.sv
      - logic/branch_core_top.sv
  - target: test
    include_dirs:
      - include
      - bench
    files:
      - bench/branch_core_tb.sv

//--- bench/branch_core_table.svh
`ifndef BRANCH_CORE_TABLE_SVH
`define BRANCH_CORE_TABLE_SVH

// columns: instruction, pc, write valid, write dest, write data, branch taken, branch target
// the write is due 4 cycles after issue and the branch 2 cycles after issue
task automatic build_table();
  add_row(imm8_word(`OP_LBI, 3'd1, 8'h05), 16'h0100, 1'b1, 3'd1, 16'h0005, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_LBI, 3'd2, 8'h80), 16'h0102, 1'b1, 3'd2, 16'hff80, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_LBI, 3'd3, 8'h00), 16'h0104, 1'b1, 3'd3, 16'h0000, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_SLBI, 3'd1, 8'h34), 16'h0106, 1'b1, 3'd1, 16'h0534, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_LBI, 3'd5, 8'h7f), 16'h0108, 1'b1, 3'd5, 16'h007f, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_LBI, 3'd6, 8'h01), 16'h010a, 1'b1, 3'd6, 16'h0001, 1'b0, 16'h0000);
  add_row(reg_word(`OP_ADD, 3'd1, 3'd2, 3'd4, `FN_ADD), 16'h010c, 1'b1, 3'd4, 16'h04b4, 1'b0, 16'h0000);
  add_row(reg_word(`OP_SUB, 3'd5, 3'd1, 3'd0, `FN_SUB), 16'h010e, 1'b1, 3'd0, 16'h04b5, 1'b0, 16'h0000);
  add_row(imm5_word(`OP_ADDI, 3'd6, 3'd2, 5'h1d), 16'h0110, 1'b1, 3'd2, 16'hfffe, 1'b0, 16'h0000);
  add_row(imm5_word(`OP_SUBI, 3'd5, 3'd6, 5'h04), 16'h0112, 1'b1, 3'd6, 16'hff85, 1'b0, 16'h0000);
  add_row(imm5_word(`OP_STU, 3'd1, 3'd0, 5'h02), 16'h0114, 1'b1, 3'd1, 16'h0536, 1'b0, 16'h0000);
  // r3 turns nonzero two ahead of the beqz, the stale zero would take it
  add_row(imm8_word(`OP_LBI, 3'd3, 8'h09), 16'h0116, 1'b1, 3'd3, 16'h0009, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_NOP, 3'd0, 8'h00), 16'h0118, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_BEQZ, 3'd3, 8'h10), 16'h011a, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_LBI, 3'd3, 8'h00), 16'h011c, 1'b1, 3'd3, 16'h0000, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_NOP, 3'd0, 8'h00), 16'h011e, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_BEQZ, 3'd3, 8'hf0), 16'h0120, 1'b0, 3'd0, 16'h0000, 1'b1, 16'h0112);
  add_row(imm8_word(`OP_NOP, 3'd0, 8'h00), 16'h0122, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  // stu writes its own rs, which the bnez then picks up from the memory latch
  add_row(imm5_word(`OP_STU, 3'd3, 3'd0, 5'h03), 16'h0124, 1'b1, 3'd3, 16'h0003, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_NOP, 3'd0, 8'h00), 16'h0126, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_BNEZ, 3'd3, 8'h20), 16'h0128, 1'b0, 3'd0, 16'h0000, 1'b1, 16'h014a);
  add_row(imm8_word(`OP_NOP, 3'd0, 8'h00), 16'h012a, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  // jal links pc + 2 into r7 and jr r7 jumps through that link
  add_row(disp_word(`OP_JAL, 11'h010), 16'h012c, 1'b1, 3'd7, 16'h012e, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_NOP, 3'd0, 8'h00), 16'h012e, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_JR, 3'd7, 8'h04), 16'h0130, 1'b0, 3'd0, 16'h0000, 1'b1, 16'h0132);
  add_row(imm8_word(`OP_NOP, 3'd0, 8'h00), 16'h0132, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  // jalr jumps through the new r5 that the memory latch forwards
  add_row(imm8_word(`OP_LBI, 3'd5, 8'h40), 16'h0134, 1'b1, 3'd5, 16'h0040, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_NOP, 3'd0, 8'h00), 16'h0136, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_JALR, 3'd5, 8'h00), 16'h0138, 1'b1, 3'd7, 16'h013a, 1'b1, 16'h0040);
  add_row(imm8_word(`OP_NOP, 3'd0, 8'h00), 16'h013a, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  add_row(disp_word(`OP_J, 11'h540), 16'h013c, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  // memory latch writes r2 while the bltz reads r6 from the register file
  add_row(imm8_word(`OP_LBI, 3'd2, 8'h00), 16'h013e, 1'b1, 3'd2, 16'h0000, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_NOP, 3'd0, 8'h00), 16'h0140, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_BLTZ, 3'd6, 8'h06), 16'h0142, 1'b0, 3'd0, 16'h0000, 1'b1, 16'h014a);
  add_row(imm8_word(`OP_NOP, 3'd0, 8'h00), 16'h0144, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  // producer three ahead arrives through the writeback bypass
  add_row(imm8_word(`OP_LBI, 3'd4, 8'h80), 16'h0146, 1'b1, 3'd4, 16'hff80, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_NOP, 3'd0, 8'h00), 16'h0148, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_NOP, 3'd0, 8'h00), 16'h014a, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_BLTZ, 3'd4, 8'hfe), 16'h014c, 1'b0, 3'd0, 16'h0000, 1'b1, 16'h014c);
  add_row(disp_word(`OP_HALT, 11'h000), 16'h014e, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_BLTZ, 3'd5, 8'h10), 16'h0150, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_BGEZ, 3'd6, 8'h10), 16'h0152, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_LBI, 3'd6, 8'h10), 16'h0154, 1'b1, 3'd6, 16'h0010, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_NOP, 3'd0, 8'h00), 16'h0156, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
  add_row(imm8_word(`OP_BGEZ, 3'd6, 8'h02), 16'h0158, 1'b0, 3'd0, 16'h0000, 1'b1, 16'h015c);
  add_row(imm8_word(`OP_NOP, 3'd0, 8'h00), 16'h015a, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000);
endtask

`endif

//--- bench/branch_core_tb.sv
`timescale 1ns/1ps
`include "wisc_defs.svh"

module branch_core_tb;
  import wisc_pkg::*;

  localparam int MAX_ROWS = 64;

  logic                    clk;
  logic                    rst_n;
  instr_u                  instr_in;
  logic [`WISC_DATA_W-1:0] pc_in;
  logic                    instr_valid;
  logic                    branch_taken;
  logic [`WISC_DATA_W-1:0] branch_target;
  logic                    wb_valid;
  logic [`WISC_REG_W-1:0]  wb_dest;
  logic [`WISC_DATA_W-1:0] wb_data;

  logic [15:0] row_instr  [MAX_ROWS];
  logic [15:0] row_pc     [MAX_ROWS];
  logic        row_write  [MAX_ROWS]; // expected wb_valid 4 cycles after issue
  logic [2:0]  row_dest   [MAX_ROWS];
  logic [15:0] row_data   [MAX_ROWS];
  logic        row_taken  [MAX_ROWS]; // expected branch_taken 2 cycles after issue
  logic [15:0] row_target [MAX_ROWS];
  int          row_count = 0;
  int          cycle_count = 0;
  int          checks = 0;
  int          write_errors = 0;
  int          branch_errors = 0;
  int          reset_errors = 0;
  integer      seed;
  int          in_flight [$]; // row index per issue cycle, newest first, -1 when idle

  branch_core_top branch_core_top_i (
    .clk(clk), .rst_n(rst_n), .instr_in(instr_in), .pc_in(pc_in),
    .instr_valid(instr_valid), .branch_taken(branch_taken),
    .branch_target(branch_target), .wb_valid(wb_valid), .wb_dest(wb_dest),
    .wb_data(wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  function automatic logic [15:0] imm8_word(input logic [4:0] op, input logic [2:0] rs,
                                            input logic [7:0] imm8);
    return {op, rs, imm8}; // lbi, slbi, branches, jr and jalr
  endfunction

  function automatic logic [15:0] imm5_word(input logic [4:0] op, input logic [2:0] rs,
                                            input logic [2:0] rd, input logic [4:0] imm5);
    return {op, rs, rd, imm5};
  endfunction

  function automatic logic [15:0] reg_word(input logic [4:0] op, input logic [2:0] rs,
                                           input logic [2:0] rt, input logic [2:0] rd,
                                           input logic [1:0] func);
    return {op, rs, rt, rd, func};
  endfunction

  function automatic logic [15:0] disp_word(input logic [4:0] op, input logic [10:0] disp);
    return {op, disp}; // j, jal and halt carry an 11-bit field
  endfunction

  task automatic add_row(input logic [15:0] instr, input logic [15:0] pc, input logic wr,
                         input logic [2:0] dest, input logic [15:0] data,
                         input logic taken, input logic [15:0] target);
    row_instr[row_count]  = instr;
    row_pc[row_count]     = pc;
    row_write[row_count]  = wr;
    row_dest[row_count]   = dest;
    row_data[row_count]   = data;
    row_taken[row_count]  = taken;
    row_target[row_count] = target;
    row_count++;
  endtask

  `include "branch_core_table.svh"

  // row_b was issued 2 cycles ago, row_w 4 cycles ago
  task automatic check_outputs(input int row_b, input int row_w);
    logic exp_taken;
    logic exp_write;
    exp_taken = 1'b0;
    exp_write = 1'b0;
    if (row_b >= 0) exp_taken = row_taken[row_b];
    if (row_w >= 0) exp_write = row_write[row_w];
    checks++;
    if (branch_taken !== exp_taken) begin
      $display("mismatch at %0t: row %0d branch_taken %b, expected %b",
               $time, row_b, branch_taken, exp_taken);
      branch_errors++;
    end else if (exp_taken && branch_target !== row_target[row_b]) begin
      $display("mismatch at %0t: row %0d branch_target %h, expected %h",
               $time, row_b, branch_target, row_target[row_b]);
      branch_errors++;
    end
    if (wb_valid !== exp_write) begin
      $display("mismatch at %0t: row %0d wb_valid %b, expected %b",
               $time, row_w, wb_valid, exp_write);
      write_errors++;
    end else if (exp_write && (wb_dest !== row_dest[row_w] || wb_data !== row_data[row_w])) begin
      $display("mismatch at %0t: row %0d wrote r%0d=%h, expected r%0d=%h", $time, row_w,
               wb_dest, wb_data, row_dest[row_w], row_data[row_w]);
      write_errors++;
    end
  endtask

  // the run may take the table length plus reset and pipeline drain
  initial begin
    while (cycle_count < row_count + 30) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the table never finished", cycle_count);
    $display("Test failures found");
    $finish;
  end

  initial begin
    logic [15:0] word;
    logic [31:0] rnd;
    seed        = 10303;
    rst_n       = 1'b0;
    instr_in    = '0;
    pc_in       = '0;
    instr_valid = 1'b0;
    build_table();
    repeat (10) begin
      @(negedge clk);
      if (branch_taken !== 1'b0 || wb_valid !== 1'b0) begin
        $display("mismatch at %0t: branch_taken %b wb_valid %b during reset",
                 $time, branch_taken, wb_valid);
        reset_errors++;
      end
    end
    @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) in_flight.push_front(-1); // nothing in the pipeline yet
    for (int i = 0; i < row_count + 4; i++) begin
      @(posedge clk);
      if (i < row_count) begin
        word = row_instr[i];
        if (word[15:11] == `OP_NOP) begin
          rnd = $random(seed);
          word[10:0] = rnd[10:0]; // nop ignores its operand bits
        end
        instr_in    <= word;
        pc_in       <= row_pc[i];
        instr_valid <= 1'b1;
        in_flight.push_front(i);
      end else begin
        instr_in    <= '0;
        instr_valid <= 1'b0; // drain with bubbles
        in_flight.push_front(-1);
      end
      @(negedge clk);
      check_outputs(in_flight[2], in_flight[4]);
      void'(in_flight.pop_back());
    end
    $display("%0d checks, %0d write errors, %0d branch errors, %0d reset errors",
             checks, write_errors, branch_errors, reset_errors);
    if (write_errors + branch_errors + reset_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
+incdir+bench
logic/wisc_pkg.sv
logic/decode_stage.sv
logic/decode_forward.sv
logic/branch_resolve.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/branch_core_top.sv
bench/branch_core_tb.sv

//--- include/wisc_defs.svh
`ifndef WISC_DEFS_SVH
`define WISC_DEFS_SVH

// machine widths, fixed by the ISA
`define WISC_DATA_W 16
`define WISC_REG_W 3
`define WISC_NUM_REGS 8
`define WISC_IMM_W 5

// the opcode sits in the top five bits of every instruction word
`define WISC_OP_MSB 15
`define WISC_OP_LSB 11
`define WISC_OP_W (`WISC_OP_MSB - `WISC_OP_LSB + 1)

`define WISC_R7 3'd7 // link register written by jal and jalr

`define OP_HALT 5'b00000
`define OP_NOP  5'b00001
`define OP_SIIC 5'b00010
`define OP_RTI  5'b00011
`define OP_J    5'b00100
`define OP_JR   5'b00101
`define OP_JAL  5'b00110
`define OP_JALR 5'b00111
`define OP_ADDI 5'b01000
`define OP_SUBI 5'b01001
`define OP_BEQZ 5'b01100
`define OP_BNEZ 5'b01101
`define OP_BLTZ 5'b01110
`define OP_BGEZ 5'b01111
`define OP_SLBI 5'b10010
`define OP_STU  5'b10011
`define OP_LBI  5'b11000
`define OP_ADD  5'b11011 // add and sub share one opcode and differ in func
`define OP_SUB  5'b11011
`define FN_ADD  2'b00
`define FN_SUB  2'b01

`endif

//--- logic/branch_core_top.sv
`timescale 1ns/1ps
`include "wisc_defs.svh"

module branch_core_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  wisc_pkg::instr_u        instr_in,
  input  logic [`WISC_DATA_W-1:0] pc_in,         // link and branch base are pc_in + 2
  input  logic                    instr_valid,
  output logic                    branch_taken,  // high in the second cycle after issue
  output logic [`WISC_DATA_W-1:0] branch_target,
  output logic                    wb_valid,      // high in the fourth cycle after issue
  output logic [`WISC_REG_W-1:0]  wb_dest,
  output logic [`WISC_DATA_W-1:0] wb_data
);
  import wisc_pkg::*;

  dec_ex_s                 dec;
  ex_mem_s                 mem_stage;
  wb_s                     wb;
  instr_u                  instr_d;
  logic [`WISC_REG_W-1:0]  rs_d;
  logic [`WISC_DATA_W-1:0] rs_data;
  logic                    valid_d;
  logic [`WISC_DATA_W-1:0] pc_d;
  logic [`WISC_DATA_W-1:0] rs_fwd;

  decode_stage decode_stage_i (
    .clk(clk), .rst_n(rst_n), .instr_in(instr_in), .pc_in(pc_in),
    .instr_valid(instr_valid), .wb(wb), .dec(dec), .instr_d(instr_d),
    .rs_d(rs_d), .rs_data(rs_data), .valid_d(valid_d), .pc_d(pc_d)
  );

  decode_forward decode_forward_i (
    .execute_data(mem_stage.result), .data_rs(rs_data), .rs_d(rs_d),
    .mem_stage(mem_stage), .instruction_d(instr_d), .data_rs_o(rs_fwd)
  );

  branch_resolve branch_resolve_i (
    .clk(clk), .rst_n(rst_n), .instruction_d(instr_d), .valid_d(valid_d),
    .pc_d(pc_d), .rs_value(rs_fwd), .branch_taken(branch_taken),
    .branch_target(branch_target)
  );

  execute_stage execute_stage_i (.clk(clk), .rst_n(rst_n), .dec(dec), .mem_stage(mem_stage));

  writeback_stage writeback_stage_i (.clk(clk), .rst_n(rst_n), .mem_stage(mem_stage), .wb(wb));

  // the write report is the register file write port itself
  assign wb_valid = wb.valid;
  assign wb_dest  = wb.dest;
  assign wb_data  = wb.data;

endmodule

//--- logic/branch_resolve.sv
`timescale 1ns/1ps
`include "wisc_defs.svh"

module branch_resolve (
  input  logic                    clk,
  input  logic                    rst_n,
  input  wisc_pkg::instr_u        instruction_d,
  input  logic                    valid_d,
  input  logic [`WISC_DATA_W-1:0] pc_d,      // pc + 2 of the decode instruction
  input  logic [`WISC_DATA_W-1:0] rs_value,  // rs after forwarding
  output logic                    branch_taken,
  output logic [`WISC_DATA_W-1:0] branch_target
);
  import wisc_pkg::*;

  logic [`WISC_OP_W-1:0]   op;
  logic [7:0]              imm8;
  logic [`WISC_DATA_W-1:0] imm8_sext;
  logic                    rs_zero;
  logic                    rs_neg;
  logic                    taken_n;
  logic [`WISC_DATA_W-1:0] target_n;

  assign op        = instruction_d.i_form.opcode;
  assign imm8      = {instruction_d.i_form.rd, instruction_d.i_form.imm}; // low byte
  assign imm8_sext = {{(`WISC_DATA_W - 8){imm8[7]}}, imm8};
  assign rs_zero   = (rs_value == '0);
  assign rs_neg    = rs_value[`WISC_DATA_W-1];

  always_comb begin
    case (op)
      `OP_BEQZ: taken_n = rs_zero;
      `OP_BNEZ: taken_n = !rs_zero;
      `OP_BLTZ: taken_n = rs_neg;
      `OP_BGEZ: taken_n = !rs_neg;
      `OP_JR,
      `OP_JALR: taken_n = 1'b1;
      default:  taken_n = 1'b0; // j and jal are not resolved here
    endcase
  end

  // register jumps add to rs, conditional branches add to pc + 2
  assign target_n = (op == `OP_JR || op == `OP_JALR) ? rs_value + imm8_sext
                                                     : pc_d + imm8_sext;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      branch_taken <= 1'b0;
    end else begin
      branch_taken <= valid_d && taken_n; // one cycle pulse per taken branch
    end
  end

  always_ff @(posedge clk) begin
    branch_target <= target_n;
  end

endmodule

//--- logic/decode_forward.sv
`timescale 1ns/1ps
`include "wisc_defs.svh"

module decode_forward (
  input  logic [`WISC_DATA_W-1:0] execute_data,  // result held in the memory latch
  input  logic [`WISC_DATA_W-1:0] data_rs,       // rs as read from the register file
  input  logic [`WISC_REG_W-1:0]  rs_d,
  input  wisc_pkg::ex_mem_s       mem_stage,
  input  wisc_pkg::instr_u        instruction_d,
  output logic [`WISC_DATA_W-1:0] data_rs_o
);
  import wisc_pkg::*;

  logic [`WISC_OP_W-1:0] opcode_d;
  logic [`WISC_OP_W-1:0] opcode_m;
  logic                  mem_write_rd;
  logic                  mem_write_rs;
  logic                  mem_write_r7;
  logic                  branch;
  logic                  no_forward_rs;
  logic                  replace_rs_mem;

  assign opcode_d = instruction_d.i_form.opcode;
  assign opcode_m = mem_stage.instr.i_form.opcode;

  // the three ways the memory-latch instruction can write a register
  assign mem_write_rd = mem_stage.valid && mem_stage.valid_rd && mem_stage.reg_write;
  assign mem_write_rs = mem_stage.valid &&
                        (opcode_m == `OP_STU || opcode_m == `OP_LBI || opcode_m == `OP_SLBI);
  assign mem_write_r7 = mem_stage.valid && (opcode_m == `OP_JAL || opcode_m == `OP_JALR);

  // only the instructions resolved in decode need the early value
  assign branch = (opcode_d == `OP_BEQZ) || (opcode_d == `OP_BNEZ) ||
                  (opcode_d == `OP_BLTZ) || (opcode_d == `OP_BGEZ) ||
                  (opcode_d == `OP_JR)   || (opcode_d == `OP_JALR);

  // opcodes that never read rs as a source
  assign no_forward_rs = (opcode_d == `OP_J)    || (opcode_d == `OP_NOP)  ||
                         (opcode_d == `OP_LBI)  || (opcode_d == `OP_HALT) ||
                         (opcode_d == `OP_SIIC) || (opcode_d == `OP_RTI);

  // any write path whose target index matches rs triggers the replacement
  assign replace_rs_mem = !no_forward_rs &&
                          ((mem_write_rd && rs_d == mem_stage.rd) ||
                           (mem_write_rs && rs_d == mem_stage.rs) ||
                           (mem_write_r7 && rs_d == `WISC_R7));

  // a producer one ahead is not covered here, the program spaces it out
  assign data_rs_o = (branch && replace_rs_mem) ? execute_data : data_rs;

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps
`include "wisc_defs.svh"

module decode_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  wisc_pkg::instr_u        instr_in,
  input  logic [`WISC_DATA_W-1:0] pc_in,       // address of the incoming instruction
  input  logic                    instr_valid,
  input  wisc_pkg::wb_s           wb,          // register file write port
  output wisc_pkg::dec_ex_s       dec,         // registered bundle for execute
  output wisc_pkg::instr_u        instr_d,     // instruction sitting in decode
  output logic [`WISC_REG_W-1:0]  rs_d,
  output logic [`WISC_DATA_W-1:0] rs_data,     // rs read with the writeback bypass
  output logic                    valid_d,     // decode holds a real instruction
  output logic [`WISC_DATA_W-1:0] pc_d         // pc + 2 of the decode instruction
);
  import wisc_pkg::*;

  logic [`WISC_DATA_W-1:0] rf [`WISC_NUM_REGS];
  logic [`WISC_DATA_W-1:0] pc_q;
  logic [`WISC_DATA_W-1:0] rt_data;
  logic [`WISC_REG_W-1:0]  rt_d;
  logic [`WISC_OP_W-1:0]   op;
  logic                    alu_rr;
  logic                    alu_imm;
  logic                    write_rd;
  logic                    write_rs;
  logic                    write_r7;
  dec_ex_s                 dec_n;

  // decode latch, a cycle without the strobe leaves a bubble behind
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_d <= 1'b0;
    end else begin
      valid_d <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      instr_d <= instr_in;
      pc_q    <= pc_in;
    end
  end

  assign pc_d = pc_q + `WISC_DATA_W'd2; // link value and branch base

  // eight registers, written on the edge that ends the writeback cycle
  always_ff @(posedge clk) begin
    if (wb.valid) begin
      rf[wb.dest] <= wb.data;
    end
  end

  assign rs_d = instr_d.r_form.rs; // rs sits in the same bits in both formats
  assign rt_d = instr_d.r_form.rt;

  // a write landing this cycle is seen right away instead of next cycle
  assign rs_data = (wb.valid && wb.dest == rs_d) ? wb.data : rf[rs_d];
  assign rt_data = (wb.valid && wb.dest == rt_d) ? wb.data : rf[rt_d];

  assign op = instr_d.r_form.opcode;

  // only the add and sub func codes are implemented under the shared opcode
  assign alu_rr   = (op == `OP_ADD && instr_d.r_form.func == `FN_ADD) ||
                    (op == `OP_SUB && instr_d.r_form.func == `FN_SUB);
  assign alu_imm  = (op == `OP_ADDI) || (op == `OP_SUBI);
  assign write_rd = valid_d && (alu_rr || alu_imm);
  assign write_rs = valid_d && (op == `OP_STU || op == `OP_LBI || op == `OP_SLBI);
  assign write_r7 = valid_d && (op == `OP_JAL || op == `OP_JALR);

  always_comb begin
    dec_n.valid     = valid_d;
    dec_n.instr     = instr_d;
    dec_n.rs_data   = rs_data;
    dec_n.rt_data   = rt_data;
    dec_n.rd        = alu_rr ? instr_d.r_form.rd : instr_d.i_form.rd; // rd moves with format
    dec_n.reg_write = write_rd || write_rs || write_r7;
    dec_n.valid_rd  = write_rd;
    dec_n.write_rs  = write_rs;
    dec_n.write_r7  = write_r7;
    dec_n.pc_link   = pc_d;
  end

  // decode-to-execute latch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec <= '0;
    end else begin
      dec <= dec_n;
    end
  end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps
`include "wisc_defs.svh"

module execute_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  wisc_pkg::dec_ex_s  dec,
  output wisc_pkg::ex_mem_s  mem_stage
);
  import wisc_pkg::*;

  logic [`WISC_OP_W-1:0]   op;
  logic [`WISC_DATA_W-1:0] rs_val;
  logic [`WISC_DATA_W-1:0] rt_val;
  logic [`WISC_DATA_W-1:0] imm5_sext;
  logic [7:0]              imm8;
  logic [`WISC_DATA_W-1:0] imm8_sext;
  logic [`WISC_DATA_W-1:0] result;
  ex_mem_s                 mem_n;

  assign op     = dec.instr.i_form.opcode;
  assign rs_val = dec.rs_data;
  assign rt_val = dec.rt_data;

  assign imm5_sext = {{(`WISC_DATA_W - `WISC_IMM_W){dec.instr.i_form.imm[`WISC_IMM_W-1]}},
                      dec.instr.i_form.imm};
  assign imm8      = {dec.instr.i_form.rd, dec.instr.i_form.imm};
  assign imm8_sext = {{(`WISC_DATA_W - 8){imm8[7]}}, imm8};

  always_comb begin
    if (dec.write_r7) begin
      result = dec.pc_link; // jal and jalr store the return address
    end else if (dec.write_rs) begin
      case (op)
        `OP_LBI:  result = imm8_sext;
        `OP_SLBI: result = {rs_val[7:0], imm8}; // shift up a byte and fill the low byte
        default:  result = rs_val + imm5_sext;  // stu keeps only the updated address
      endcase
    end else if (op == `OP_ADDI) begin
      result = rs_val + imm5_sext;
    end else if (op == `OP_SUBI) begin
      result = imm5_sext - rs_val; // the ISA subtracts rs from the immediate
    end else if (dec.instr.r_form.func == `FN_SUB) begin
      result = rt_val - rs_val;    // sub takes rs away from rt as well
    end else begin
      result = rs_val + rt_val;
    end
  end

  // destination and write flags travel along with the result
  always_comb begin
    mem_n.valid     = dec.valid;
    mem_n.instr     = dec.instr;
    mem_n.result    = result;
    mem_n.rd        = dec.rd;
    mem_n.rs        = dec.instr.i_form.rs;
    mem_n.reg_write = dec.reg_write;
    mem_n.valid_rd  = dec.valid_rd;
  end

  // execute-to-memory latch, which the forwarding block reads back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_stage <= '0;
    end else begin
      mem_stage <= mem_n;
    end
  end

endmodule

//--- logic/wisc_pkg.sv
`include "wisc_defs.svh"

package wisc_pkg;

  // register-register layout, used by add and sub
  typedef struct packed {
    logic [`WISC_OP_W-1:0]  opcode; // bits 15:11 in every format
    logic [`WISC_REG_W-1:0] rs;
    logic [`WISC_REG_W-1:0] rt;
    logic [`WISC_REG_W-1:0] rd;
    logic [1:0]             func;   // picks add or sub under the shared opcode
  } r_form_s;

  // immediate layout; lbi, slbi and the branches read {rd, imm} as one byte
  typedef struct packed {
    logic [`WISC_OP_W-1:0]  opcode;
    logic [`WISC_REG_W-1:0] rs;
    logic [`WISC_REG_W-1:0] rd;
    logic [`WISC_IMM_W-1:0] imm;
  } i_form_s;

  typedef union packed {
    r_form_s r_form;
    i_form_s i_form;
  } instr_u;

  typedef struct packed {
    logic                    valid;
    instr_u                  instr;
    logic [`WISC_DATA_W-1:0] rs_data;
    logic [`WISC_DATA_W-1:0] rt_data;
    logic [`WISC_REG_W-1:0]  rd;        // already resolved between the two formats
    logic                    reg_write; // any register write at all
    logic                    valid_rd;  // the write goes to rd
    logic                    write_rs;  // stu, lbi and slbi write back into rs
    logic                    write_r7;  // jal and jalr write the link
    logic [`WISC_DATA_W-1:0] pc_link;   // address of the next instruction
  } dec_ex_s;

  typedef struct packed {
    logic                    valid;
    instr_u                  instr;     // downstream decodes the rs and R7 writers from it
    logic [`WISC_DATA_W-1:0] result;
    logic [`WISC_REG_W-1:0]  rd;
    logic [`WISC_REG_W-1:0]  rs;
    logic                    reg_write;
    logic                    valid_rd;
  } ex_mem_s;

  typedef struct packed {
    logic                    valid;
    logic [`WISC_REG_W-1:0]  dest;
    logic [`WISC_DATA_W-1:0] data;
  } wb_s;

endpackage

//--- logic/writeback_stage.sv
`timescale 1ns/1ps
`include "wisc_defs.svh"

module writeback_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  wisc_pkg::ex_mem_s  mem_stage,
  output wisc_pkg::wb_s      wb
);
  import wisc_pkg::*;

  logic [`WISC_OP_W-1:0]  op;
  logic [`WISC_REG_W-1:0] dest;
  wb_s                    wb_n;

  assign op = mem_stage.instr.i_form.opcode;

  // the target register comes from the opcode and not from one fixed field
  always_comb begin
    if (op == `OP_JAL || op == `OP_JALR) begin
      dest = `WISC_R7;
    end else if (op == `OP_LBI || op == `OP_SLBI || op == `OP_STU) begin
      dest = mem_stage.rs;
    end else begin
      dest = mem_stage.rd;
    end
  end

  assign wb_n.valid = mem_stage.valid && mem_stage.reg_write; // bubbles and non-writers drop out
  assign wb_n.dest  = dest;
  assign wb_n.data  = mem_stage.result;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb <= '0;
    end else begin
      wb <= wb_n;
    end
  end

endmodule
